//--- verilog.f
source/scu_pkg.sv
source/scu_dr_chain.sv
source/scu_regs.sv
source/scu_reset_buf.sv
source/scu_reset_ctrl.sv
source/scu_top.sv
tests/scu_assertions.sv
tests/scu_tb.sv

//--- tests/scu_tb.sv
//======================================================================
// Directed testbench for the system control unit. Drives the scan
// chain and the reset requests, checks register readback and the four
// reset domains. Ends with a summary line and the run verdict.
//======================================================================

`timescale 1ns/100ps

module scu_tb;
    import scu_pkg::*;

    localparam int clk_period = 20;
    localparam int num_tests  = 5;
    localparam int wait_bound = 20;     // Cycles allowed for a reset to move
    localparam int sys_idx    = 0;
    localparam int core_idx   = 1;
    localparam int dm_idx     = 2;
    localparam int hdu_idx    = 3;

    logic clk;
    logic pwrup_rst_n_sync;
    logic rst_n;
    logic cpu_rst_n;
    logic ndm_rst_n;
    logic hart_rst_n;
    logic tapc_ch_sel;
    logic tapc_ch_id;
    logic tapc_ch_capture;
    logic tapc_ch_shift;
    logic tapc_ch_update;
    logic tapc_ch_tdi;
    logic tapc_ch_tdo;
    logic sys_rst_n;
    logic sys_rst_n_qlfy;
    logic core_rst_n;
    logic core_rst_n_qlfy;
    logic dm_rst_n;
    logic dm_rst_n_qlfy;
    logic hdu_rst_n;
    logic hdu_rst_n_qlfy;

    logic [7:0] lfsr_q = 8'd34;
    int         errors = 0;
    int         tests_failed = 0;
    int         assert_fails;
    string      reset_names[4] = '{"sys_rst_n", "core_rst_n", "dm_rst_n", "hdu_rst_n"};

    scu_top #(.rst_buf_stages(2)) dut (.*);

    always #(clk_period / 2) clk = ~clk;

    //==================================================================
    // Helpers
    //==================================================================
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);   // x^8+x^6+x^5+x^4+1
    endfunction

    task automatic random_nibble(output logic [3:0] val);
        for (int i = 0; i < 4; i++) begin
            val[i] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        errors++;
    endtask

    // Starts and ends on a falling edge
    task automatic scan_cmd(input scu_op_e op, input scu_addr_e addr,
                            input logic [3:0] data, output logic [7:0] captured);
        scu_dr_s word;
        word.data = data;
        word.addr = addr;
        word.op   = op;
        tapc_ch_sel     = 1'b1;
        tapc_ch_capture = 1'b1;
        @(negedge clk);
        tapc_ch_capture = 1'b0;
        tapc_ch_shift   = 1'b1;
        for (int i = 0; i < scu_dr_w; i++) begin
            tapc_ch_tdi = word[i];
            captured[i] = tapc_ch_tdo;      // LSB of the old shadow first
            @(negedge clk);
        end
        tapc_ch_shift  = 1'b0;
        tapc_ch_update = 1'b1;
        @(negedge clk);
        tapc_ch_update = 1'b0;
        tapc_ch_sel    = 1'b0;
    endtask

    task automatic reg_read(input scu_addr_e addr, output logic [3:0] val);
        logic [7:0] word;
        scan_cmd(scu_op_read, addr, 4'h0, word);
        scan_cmd(scu_op_read, addr, 4'h0, word);   // Collects the first read
        if (word[3:0] !== {addr, scu_op_read}) begin
            report_mismatch("echoed command", word[3:0], {addr, scu_op_read});
        end
        val = word[7:4];
    endtask

    function automatic logic reset_level(input int idx);
        case (idx)
            sys_idx:  return sys_rst_n;
            core_idx: return core_rst_n;
            dm_idx:   return dm_rst_n;
            default:  return hdu_rst_n;
        endcase
    endfunction

    task automatic wait_level(input int idx, input logic level);
        int cycles;
        cycles = 0;
        while (reset_level(idx) !== level && cycles < wait_bound) begin
            @(negedge clk);
            cycles++;
        end
        if (reset_level(idx) !== level) begin
            $display("%s did not go to %0d within %0d cycles",
                     reset_names[idx], level, wait_bound);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start);
        if (errors == start) begin
            $display("%s passed", name);
        end else begin
            $display("%s failed with %0d errors", name, errors - start);
            tests_failed++;
        end
    endtask

    // Write, set bits and clear bits with a running model of the register
    task automatic merge_check(input scu_addr_e addr, input logic [3:0] keep,
                               input string name);
        logic [3:0] d;
        logic [3:0] model;
        logic [3:0] val;
        logic [7:0] word;
        random_nibble(d);
        model = d & keep;
        scan_cmd(scu_op_write, addr, d & keep, word);
        reg_read(addr, val);
        if (val !== model) report_mismatch({name, " after write"}, val, model);
        random_nibble(d);
        model = model | (d & keep);
        scan_cmd(scu_op_setbits, addr, d & keep, word);
        reg_read(addr, val);
        if (val !== model) report_mismatch({name, " after set bits"}, val, model);
        random_nibble(d);
        model = model & ~d;
        scan_cmd(scu_op_clrbits, addr, d, word);
        reg_read(addr, val);
        if (val !== model) report_mismatch({name, " after clear bits"}, val, model);
    endtask

    //==================================================================
    // Tests
    //==================================================================
    task automatic reset_defaults();
        int         start;
        logic [3:0] val;
        logic [7:0] word;
        start = errors;
        for (int i = 0; i < 4; i++) begin
            wait_level(i, 1'b1);
        end
        scan_cmd(scu_op_clrbits, scu_addr_sticky, 4'hF, word);  // Power-up edges
        reg_read(scu_addr_control, val);
        if (val !== 4'h0) report_mismatch("CONTROL", val, 4'h0);
        reg_read(scu_addr_mode, val);
        if (val !== 4'h0) report_mismatch("MODE", val, 4'h0);
        reg_read(scu_addr_status, val);
        if (val !== 4'h0) report_mismatch("STATUS", val, 4'h0);
        reg_read(scu_addr_sticky, val);
        if (val !== 4'h0) report_mismatch("STICKY", val, 4'h0);
        finish_test("reset defaults", start);
    endtask

    task automatic register_ops();
        int         start;
        logic [3:0] val;
        logic [7:0] word;
        start = errors;
        merge_check(scu_addr_control, 4'hE, "CONTROL");     // Bit 0 would reset
        merge_check(scu_addr_mode, 4'hF, "MODE");
        reg_read(scu_addr_status, val);
        if (val !== 4'h0) report_mismatch("STATUS first read", val, 4'h0);
        reg_read(scu_addr_status, val);
        if (val !== 4'h0) report_mismatch("STATUS second read", val, 4'h0);
        scan_cmd(scu_op_write, scu_addr_control, 4'h0, word);
        scan_cmd(scu_op_write, scu_addr_mode, 4'h0, word);
        finish_test("register operations", start);
    endtask

    task automatic system_reset_cmd();
        int         start;
        logic [3:0] val;
        logic [7:0] word;
        start = errors;
        scan_cmd(scu_op_write, scu_addr_mode, 4'h2, word);     // HDU off core
        scan_cmd(scu_op_setbits, scu_addr_control, 4'h1, word);
        wait_level(sys_idx, 1'b0);
        wait_level(core_idx, 1'b0);
        if (sys_rst_n_qlfy !== 1'b0) report_mismatch("sys_rst_n_qlfy", sys_rst_n_qlfy, 1'b0);
        if (core_rst_n_qlfy !== 1'b0) report_mismatch("core_rst_n_qlfy", core_rst_n_qlfy, 1'b0);
        if (dm_rst_n_qlfy !== 1'b1) report_mismatch("dm_rst_n_qlfy", dm_rst_n_qlfy, 1'b1);
        if (hdu_rst_n_qlfy !== 1'b1) report_mismatch("hdu_rst_n_qlfy", hdu_rst_n_qlfy, 1'b1);
        reg_read(scu_addr_status, val);
        if (val !== 4'h3) report_mismatch("STATUS", val, 4'h3);
        if (dm_rst_n !== 1'b1) report_mismatch("dm_rst_n", dm_rst_n, 1'b1);
        scan_cmd(scu_op_clrbits, scu_addr_control, 4'h1, word);
        wait_level(sys_idx, 1'b1);
        wait_level(core_idx, 1'b1);
        if (sys_rst_n_qlfy !== 1'b1) report_mismatch("sys_rst_n_qlfy", sys_rst_n_qlfy, 1'b1);
        if (core_rst_n_qlfy !== 1'b1) report_mismatch("core_rst_n_qlfy", core_rst_n_qlfy, 1'b1);
        scan_cmd(scu_op_write, scu_addr_mode, 4'h0, word);
        finish_test("system reset", start);
    endtask

    task automatic sticky_clear();
        int         start;
        logic [3:0] val;
        logic [7:0] word;
        start = errors;
        reg_read(scu_addr_sticky, val);
        if (val !== 4'h3) report_mismatch("STICKY", val, 4'h3);
        scan_cmd(scu_op_write, scu_addr_sticky, 4'h0, word);
        reg_read(scu_addr_sticky, val);
        if (val !== 4'h3) report_mismatch("STICKY after write", val, 4'h3);
        scan_cmd(scu_op_clrbits, scu_addr_sticky, 4'h1, word);
        reg_read(scu_addr_sticky, val);
        if (val !== 4'h2) report_mismatch("STICKY after clear", val, 4'h2);
        scan_cmd(scu_op_clrbits, scu_addr_sticky, 4'hF, word);
        finish_test("sticky register", start);
    endtask

    task automatic core_debug_muxing();
        int         start;
        logic [7:0] word;
        start = errors;
        hart_rst_n = 1'b0;
        wait_level(core_idx, 1'b0);
        wait_level(hdu_idx, 1'b0);
        if (sys_rst_n !== 1'b1) report_mismatch("sys_rst_n", sys_rst_n, 1'b1);
        if (dm_rst_n !== 1'b1) report_mismatch("dm_rst_n", dm_rst_n, 1'b1);
        if (sys_rst_n_qlfy !== 1'b1) report_mismatch("sys_rst_n_qlfy", sys_rst_n_qlfy, 1'b1);
        if (core_rst_n_qlfy !== 1'b0) report_mismatch("core_rst_n_qlfy", core_rst_n_qlfy, 1'b0);
        if (dm_rst_n_qlfy !== 1'b1) report_mismatch("dm_rst_n_qlfy", dm_rst_n_qlfy, 1'b1);
        if (hdu_rst_n_qlfy !== 1'b0) report_mismatch("hdu_rst_n_qlfy", hdu_rst_n_qlfy, 1'b0);
        hart_rst_n = 1'b1;
        wait_level(core_idx, 1'b1);
        wait_level(hdu_idx, 1'b1);
        // HDU from power-up ignores the core
        scan_cmd(scu_op_write, scu_addr_mode, 4'h2, word);
        hart_rst_n = 1'b0;
        wait_level(core_idx, 1'b0);
        repeat (6) @(negedge clk);
        if (hdu_rst_n !== 1'b1) report_mismatch("hdu_rst_n", hdu_rst_n, 1'b1);
        hart_rst_n = 1'b1;
        wait_level(core_idx, 1'b1);
        // DM from system
        scan_cmd(scu_op_write, scu_addr_mode, 4'h1, word);
        scan_cmd(scu_op_setbits, scu_addr_control, 4'h1, word);
        wait_level(sys_idx, 1'b0);
        wait_level(dm_idx, 1'b0);
        if (dm_rst_n_qlfy !== 1'b0) report_mismatch("dm_rst_n_qlfy", dm_rst_n_qlfy, 1'b0);
        scan_cmd(scu_op_clrbits, scu_addr_control, 4'h1, word);
        for (int i = 0; i < 4; i++) begin
            wait_level(i, 1'b1);
        end
        scan_cmd(scu_op_write, scu_addr_mode, 4'h0, word);
        finish_test("core and debug muxing", start);
    endtask

    //==================================================================
    // Main sequence and watchdog
    //==================================================================
    initial begin
        clk              = 1'b0;
        pwrup_rst_n_sync = 1'b0;
        rst_n            = 1'b1;
        cpu_rst_n        = 1'b1;
        ndm_rst_n        = 1'b1;
        hart_rst_n       = 1'b1;
        tapc_ch_sel      = 1'b0;
        tapc_ch_id       = 1'b0;
        tapc_ch_capture  = 1'b0;
        tapc_ch_shift    = 1'b0;
        tapc_ch_update   = 1'b0;
        tapc_ch_tdi      = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        pwrup_rst_n_sync = 1'b1;
        reset_defaults();
        register_ops();
        system_reset_cmd();
        sticky_clear();
        core_debug_muxing();
        assert_fails = dut.u_reset_ctrl.u_assertions.fail_count;
        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 num_tests, tests_failed, errors, assert_fails);
        if (errors == 0 && tests_failed == 0 && assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(num_tests * 400 * clk_period);
        $display("Watchdog expired after %0d cycles, run stopped", num_tests * 400);
        $display("TEST FAILED");
        $finish;
    end

endmodule : scu_tb

//--- tests/scu_assertions.sv
//======================================================================
// Concurrent checks on the reset control, bound into scu_reset_ctrl.
// Covers core reset origin, qualifier lead and DM source selection.
//======================================================================

`timescale 1ns/100ps

module scu_assertions #(
    parameter int rst_buf_stages = 2
) (
    input logic clk,
    input logic pwrup_rst_n_sync,
    input logic sys_rst_n,
    input logic sys_rst_n_qlfy,
    input logic core_rst_n,
    input logic core_rst_n_qlfy,
    input logic core_rst_n_in,
    input logic dm_rst_n,
    input logic dm_rst_mux
);

    int fail_count = 0;     // Read by the testbench at the end of the run

    // Core drops only under system reset or one of its own requests
    core_origin: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(core_rst_n) |-> !sys_rst_n || !$past(core_rst_n_in, rst_buf_stages))
        else begin
            fail_count++;
            $error("core_rst_n fell without a system reset or core request");
        end

    //==================================================================
    // Qualifier leads its reset output
    //==================================================================
    sys_qlfy_lead: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(sys_rst_n) |-> !$past(sys_rst_n_qlfy, rst_buf_stages - 1))
        else begin
            fail_count++;
            $error("sys_rst_n fell before its qualifier");
        end

    core_qlfy_lead: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(core_rst_n) |-> !$past(core_rst_n_qlfy, rst_buf_stages - 1))
        else begin
            fail_count++;
            $error("core_rst_n fell before its qualifier");
        end

    // DM follows system once the buffer has filled
    dm_follows_sys: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        (dm_rst_mux && !sys_rst_n) [*rst_buf_stages] |=> !dm_rst_n)
        else begin
            fail_count++;
            $error("dm_rst_n high while selected system reset is active");
        end

endmodule : scu_assertions

bind scu_reset_ctrl scu_assertions #(.rst_buf_stages(rst_buf_stages)) u_assertions (
    .clk              (clk),
    .pwrup_rst_n_sync (pwrup_rst_n_sync),
    .sys_rst_n        (sys_rst_n),
    .sys_rst_n_qlfy   (sys_rst_n_qlfy),
    .core_rst_n       (core_rst_n),
    .core_rst_n_qlfy  (core_rst_n_qlfy),
    .core_rst_n_in    (core_rst_n_in),
    .dm_rst_n         (dm_rst_n),
    .dm_rst_mux       (mode_q.dm_rst_mux)
);

//--- source/scu_top.sv
//======================================================================
// System control unit top level. Connects the scan chain, the register
// file and the reset generation. Reset buffer depth set here.
//======================================================================

`timescale 1ns/100ps

module scu_top
    import scu_pkg::*;
#(
    parameter int rst_buf_stages = 2
) (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    input  logic rst_n,
    input  logic cpu_rst_n,
    input  logic ndm_rst_n,         // From debug module
    input  logic hart_rst_n,        // From debug module
    input  logic tapc_ch_sel,
    input  logic tapc_ch_id,
    input  logic tapc_ch_capture,
    input  logic tapc_ch_shift,
    input  logic tapc_ch_update,
    input  logic tapc_ch_tdi,
    output logic tapc_ch_tdo,
    output logic sys_rst_n,
    output logic sys_rst_n_qlfy,
    output logic core_rst_n,
    output logic core_rst_n_qlfy,
    output logic dm_rst_n,
    output logic dm_rst_n_qlfy,
    output logic hdu_rst_n,
    output logic hdu_rst_n_qlfy
);

    logic                  dr_update;
    scu_op_e               dr_op;
    scu_addr_e             dr_addr;
    logic [scu_data_w-1:0] dr_wdata;
    logic [scu_data_w-1:0] cmd_data;
    scu_control_s          control_q;
    scu_mode_s             mode_q;
    scu_mode_s             mode_next;
    logic                  mode_wr;
    scu_status_s           status;

    scu_dr_chain u_dr_chain (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .tapc_ch_sel      (tapc_ch_sel),
        .tapc_ch_id       (tapc_ch_id),
        .tapc_ch_capture  (tapc_ch_capture),
        .tapc_ch_shift    (tapc_ch_shift),
        .tapc_ch_update   (tapc_ch_update),
        .tapc_ch_tdi      (tapc_ch_tdi),
        .cmd_data         (cmd_data),
        .tapc_ch_tdo      (tapc_ch_tdo),
        .dr_update        (dr_update),
        .dr_op            (dr_op),
        .dr_addr          (dr_addr),
        .dr_wdata         (dr_wdata)
    );

    scu_regs u_regs (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .dr_update        (dr_update),
        .dr_op            (dr_op),
        .dr_addr          (dr_addr),
        .dr_wdata         (dr_wdata),
        .status           (status),
        .cmd_data         (cmd_data),
        .control_q        (control_q),
        .mode_q           (mode_q),
        .mode_next        (mode_next),
        .mode_wr          (mode_wr)
    );

    scu_reset_ctrl #(.rst_buf_stages(rst_buf_stages)) u_reset_ctrl (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n            (rst_n),
        .cpu_rst_n        (cpu_rst_n),
        .ndm_rst_n        (ndm_rst_n),
        .hart_rst_n       (hart_rst_n),
        .control_q        (control_q),
        .mode_q           (mode_q),
        .mode_next        (mode_next),
        .mode_wr          (mode_wr),
        .sys_rst_n        (sys_rst_n),
        .sys_rst_n_qlfy   (sys_rst_n_qlfy),
        .core_rst_n       (core_rst_n),
        .core_rst_n_qlfy  (core_rst_n_qlfy),
        .dm_rst_n         (dm_rst_n),
        .dm_rst_n_qlfy    (dm_rst_n_qlfy),
        .hdu_rst_n        (hdu_rst_n),
        .hdu_rst_n_qlfy   (hdu_rst_n_qlfy),
        .status           (status)
    );

endmodule : scu_top

//--- source/scu_reset_ctrl.sv
//======================================================================
// Reset generation for system, core, debug module and hart debug unit.
// Selects each domain's source and forwards MODE writes straight to the
// DM and HDU qualifiers.
//======================================================================

`timescale 1ns/100ps

module scu_reset_ctrl
    import scu_pkg::*;
#(
    parameter int rst_buf_stages = 2
) (
    input  logic         clk,
    input  logic         pwrup_rst_n_sync,
    input  logic         rst_n,
    input  logic         cpu_rst_n,
    input  logic         ndm_rst_n,
    input  logic         hart_rst_n,
    input  scu_control_s control_q,
    input  scu_mode_s    mode_q,
    input  scu_mode_s    mode_next,
    input  logic         mode_wr,
    output logic         sys_rst_n,
    output logic         sys_rst_n_qlfy,
    output logic         core_rst_n,
    output logic         core_rst_n_qlfy,
    output logic         dm_rst_n,
    output logic         dm_rst_n_qlfy,
    output logic         hdu_rst_n,
    output logic         hdu_rst_n_qlfy,
    output scu_status_s  status
);

    logic sys_rst_n_in;
    logic sys_rst_n_status;
    logic core_rst_n_in;
    logic core_buf_qlfy;
    logic core_rst_n_status;
    logic dm_rst_n_in;
    logic dm_buf_qlfy;
    logic dm_rst_n_status;
    logic dm_mux_fwd;
    logic dm_qlfy_i;
    logic hdu_rst_n_in;
    logic hdu_buf_qlfy;
    logic hdu_rst_n_status;
    logic hdu_mux_fwd;
    logic hdu_qlfy_i;

    //==================================================================
    // System and core
    //==================================================================
    assign sys_rst_n_in = rst_n & ~control_q.sys_reset;

    scu_reset_buf #(.rst_buf_stages(rst_buf_stages)) u_sys_buf (
        .clk              (clk),
        .rst_n            (pwrup_rst_n_sync),
        .reset_n_in       (sys_rst_n_in),
        .reset_n_out      (sys_rst_n),
        .reset_n_out_qlfy (sys_rst_n_qlfy),
        .reset_n_status   (sys_rst_n_status)
    );

    assign core_rst_n_in = cpu_rst_n & ndm_rst_n & hart_rst_n;

    scu_reset_buf #(.rst_buf_stages(rst_buf_stages)) u_core_buf (
        .clk              (clk),
        .rst_n            (sys_rst_n),          // Core sits under system
        .reset_n_in       (core_rst_n_in),
        .reset_n_out      (core_rst_n),
        .reset_n_out_qlfy (core_buf_qlfy),
        .reset_n_status   (core_rst_n_status)
    );

    assign core_rst_n_qlfy = sys_rst_n_qlfy & core_buf_qlfy;

    //==================================================================
    // Debug module and hart debug unit
    //==================================================================
    assign dm_rst_n_in  = mode_q.dm_rst_mux ? sys_rst_n : 1'b1;
    assign hdu_rst_n_in = mode_q.hdu_rst_mux ? 1'b1 : core_rst_n;

    scu_reset_buf #(.rst_buf_stages(rst_buf_stages)) u_dm_buf (
        .clk              (clk),
        .rst_n            (pwrup_rst_n_sync),
        .reset_n_in       (dm_rst_n_in),
        .reset_n_out      (dm_rst_n),
        .reset_n_out_qlfy (dm_buf_qlfy),
        .reset_n_status   (dm_rst_n_status)
    );

    scu_reset_buf #(.rst_buf_stages(rst_buf_stages)) u_hdu_buf (
        .clk              (clk),
        .rst_n            (pwrup_rst_n_sync),
        .reset_n_in       (hdu_rst_n_in),
        .reset_n_out      (hdu_rst_n),
        .reset_n_out_qlfy (hdu_buf_qlfy),
        .reset_n_status   (hdu_rst_n_status)
    );

    // Mux select seen in the same cycle as a MODE write
    assign dm_mux_fwd  = mode_wr ? mode_next.dm_rst_mux  : mode_q.dm_rst_mux;
    assign hdu_mux_fwd = mode_wr ? mode_next.hdu_rst_mux : mode_q.hdu_rst_mux;

    assign dm_rst_n_qlfy  = dm_buf_qlfy & (dm_mux_fwd ? sys_rst_n_qlfy : 1'b1);
    assign hdu_rst_n_qlfy = hdu_buf_qlfy & (hdu_mux_fwd ? 1'b1 : core_rst_n_qlfy);

    // Registered select only, no path back from cmd_data
    assign dm_qlfy_i  = dm_buf_qlfy & (mode_q.dm_rst_mux ? sys_rst_n_qlfy : 1'b1);
    assign hdu_qlfy_i = hdu_buf_qlfy & (mode_q.hdu_rst_mux ? 1'b1 : core_rst_n_qlfy);

    assign status.sys_reset  = ~(sys_rst_n_status & sys_rst_n_qlfy);
    assign status.core_reset = ~(core_rst_n_status & core_rst_n_qlfy);
    assign status.dm_reset   = ~(dm_rst_n_status & dm_qlfy_i);
    assign status.hdu_reset  = ~(hdu_rst_n_status & hdu_qlfy_i);

endmodule : scu_reset_ctrl

//--- source/scu_reset_buf.sv
//======================================================================
// Reset buffer for one domain. The first flop gives an early qualifier,
// the last one the domain reset, and one more flop the status.
//======================================================================

`timescale 1ns/100ps

module scu_reset_buf #(
    parameter int rst_buf_stages = 2    // At least 2
) (
    input  logic clk,
    input  logic rst_n,                 // Asynchronous clear of the chain
    input  logic reset_n_in,
    output logic reset_n_out,
    output logic reset_n_out_qlfy,
    output logic reset_n_status
);

    logic [rst_buf_stages-1:0] stage_q;
    logic                      status_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q  <= '0;
            status_q <= 1'b0;
        end else begin
            stage_q  <= {stage_q[rst_buf_stages-2:0], reset_n_in};
            status_q <= stage_q[rst_buf_stages-1];
        end
    end

    assign reset_n_out_qlfy = stage_q[0];                   // Warns ahead of the reset
    assign reset_n_out      = stage_q[rst_buf_stages-1];
    assign reset_n_status   = status_q;

endmodule : scu_reset_buf

//--- source/scu_regs.sv
//======================================================================
// Register file of the control unit: CONTROL, MODE, STATUS and STICKY.
// Merges each scan command with the addressed register and feeds the
// result back to the chain and to the reset control.
//======================================================================

`timescale 1ns/100ps

module scu_regs
    import scu_pkg::*;
(
    input  logic                  clk,
    input  logic                  pwrup_rst_n_sync,
    input  logic                  dr_update,
    input  scu_op_e               dr_op,
    input  scu_addr_e             dr_addr,
    input  logic [scu_data_w-1:0] dr_wdata,
    input  scu_status_s           status,       // Live reset state
    output logic [scu_data_w-1:0] cmd_data,
    output scu_control_s          control_q,
    output scu_mode_s             mode_q,
    output scu_mode_s             mode_next,
    output logic                  mode_wr
);

    logic [scu_data_w-1:0] reg_data;
    logic                  control_wr;
    logic                  sticky_wr;
    scu_status_s           status_dly_q;
    scu_status_s           status_rise;
    scu_status_s           sticky_q;

    //==================================================================
    // Register select and command merge
    //==================================================================
    always_comb begin
        case (dr_addr)
            scu_addr_control: reg_data = control_q;
            scu_addr_mode:    reg_data = mode_q;
            scu_addr_status:  reg_data = status;
            scu_addr_sticky:  reg_data = sticky_q;
            default:          reg_data = '0;
        endcase
    end

    always_comb begin
        case (dr_op)
            scu_op_write:   cmd_data = dr_wdata;
            scu_op_read:    cmd_data = reg_data;
            scu_op_setbits: cmd_data = reg_data | dr_wdata;
            scu_op_clrbits: cmd_data = reg_data & ~dr_wdata;
            default:        cmd_data = reg_data;
        endcase
    end

    // Write enables, reads never modify anything
    always_comb begin
        control_wr = 1'b0;
        mode_wr    = 1'b0;
        sticky_wr  = 1'b0;
        if (dr_update && (dr_op != scu_op_read)) begin
            case (dr_addr)
                scu_addr_control: control_wr = 1'b1;
                scu_addr_mode:    mode_wr    = 1'b1;
                scu_addr_sticky:  sticky_wr  = (dr_op == scu_op_clrbits);
                default:          ;         // STATUS is read-only
            endcase
        end
    end

    //==================================================================
    // CONTROL and MODE
    //==================================================================
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            control_q <= '0;
        end else if (control_wr) begin
            control_q <= scu_control_s'(cmd_data);
        end
    end

    assign mode_next = scu_mode_s'(cmd_data);   // Also forwarded to qualifiers

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            mode_q <= '0;
        end else if (mode_wr) begin
            mode_q <= mode_next;
        end
    end

    //==================================================================
    // Status edge detect and STICKY
    //==================================================================
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            status_dly_q <= '0;
        end else begin
            status_dly_q <= status;
        end
    end

    assign status_rise = status & ~status_dly_q;

    // New reset entry wins over a clear in the same cycle
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sticky_q <= '0;
        end else begin
            for (int i = 0; i < scu_data_w; i++) begin
                if (status_rise[i]) begin
                    sticky_q[i] <= 1'b1;
                end else if (sticky_wr) begin
                    sticky_q[i] <= cmd_data[i];
                end
            end
        end
    end

endmodule : scu_regs

//--- source/scu_dr_chain.sv
//======================================================================
// Debug scan chain of the control unit. Decodes the TAP strobes for
// chain 0, shifts the command word and keeps the shadow that the next
// capture returns to the host.
//======================================================================

`timescale 1ns/100ps

module scu_dr_chain
    import scu_pkg::*;
(
    input  logic                  clk,
    input  logic                  pwrup_rst_n_sync,
    input  logic                  tapc_ch_sel,
    input  logic                  tapc_ch_id,
    input  logic                  tapc_ch_capture,
    input  logic                  tapc_ch_shift,
    input  logic                  tapc_ch_update,
    input  logic                  tapc_ch_tdi,
    input  logic [scu_data_w-1:0] cmd_data,     // Merged result from registers
    output logic                  tapc_ch_tdo,
    output logic                  dr_update,
    output scu_op_e               dr_op,
    output scu_addr_e             dr_addr,
    output logic [scu_data_w-1:0] dr_wdata
);

    scu_dr_s shift_q;
    scu_dr_s shadow_q;
    logic    chain_hit;
    logic    dr_capture;
    logic    dr_shift;

    // Only chain id 0 belongs to this unit
    assign chain_hit  = tapc_ch_sel & ~tapc_ch_id;
    assign dr_capture = chain_hit & tapc_ch_capture;
    assign dr_shift   = chain_hit & tapc_ch_shift;
    assign dr_update  = chain_hit & tapc_ch_update;

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shift_q <= '0;
        end else if (dr_capture) begin
            shift_q <= shadow_q;                            // Last result back to host
        end else if (dr_shift) begin
            shift_q <= {tapc_ch_tdi, shift_q[scu_dr_w-1:1]}; // LSB first
        end
    end

    // Shadow holds the command with its merged data
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shadow_q <= '0;
        end else if (dr_update) begin
            shadow_q.op   <= shift_q.op;
            shadow_q.addr <= shift_q.addr;
            shadow_q.data <= cmd_data;
        end
    end

    assign dr_op       = scu_op_e'(shift_q.op);
    assign dr_addr     = scu_addr_e'(shift_q.addr);
    assign dr_wdata    = shift_q.data;
    assign tapc_ch_tdo = shift_q[0];

endmodule : scu_dr_chain

//--- source/scu_pkg.sv
//======================================================================
// Shared definitions of the system control unit: field widths, scan
// command codes and register layouts. Imported by the RTL modules and
// by the testbench.
//======================================================================

package scu_pkg;

    //==================================================================
    // Field widths
    //==================================================================
    localparam int unsigned scu_op_w   = 2;
    localparam int unsigned scu_addr_w = 2;
    localparam int unsigned scu_data_w = 4;
    localparam int unsigned scu_dr_w   = scu_data_w + scu_addr_w + scu_op_w;

    //==================================================================
    // Command codes
    //==================================================================
    typedef enum logic [scu_op_w-1:0] {
        scu_op_write   = 2'h0,
        scu_op_read    = 2'h1,
        scu_op_setbits = 2'h2,
        scu_op_clrbits = 2'h3
    } scu_op_e;

    typedef enum logic [scu_addr_w-1:0] {
        scu_addr_control = 2'h0,
        scu_addr_mode    = 2'h1,
        scu_addr_status  = 2'h2,    // Read-only
        scu_addr_sticky  = 2'h3     // Cleared only by clear-bits
    } scu_addr_e;

    // Scan word, op sits in the bits shifted out first
    typedef struct packed {
        logic [scu_data_w-1:0] data;
        logic [scu_addr_w-1:0] addr;
        logic [scu_op_w-1:0]   op;
    } scu_dr_s;

    //==================================================================
    // Register layouts
    //==================================================================
    typedef struct packed {
        logic [2:0] rsrv;
        logic       sys_reset;      // System reset request
    } scu_control_s;

    typedef struct packed {
        logic [1:0] rsrv;
        logic       hdu_rst_mux;    // 1 selects power-up for HDU
        logic       dm_rst_mux;     // 1 selects system for DM
    } scu_mode_s;

    // A set bit means the domain is in reset
    typedef struct packed {
        logic hdu_reset;
        logic dm_reset;
        logic core_reset;
        logic sys_reset;
    } scu_status_s;

endpackage : scu_pkg
